//--- src/mips_exec_defs.svh
`ifndef MIPS_EXEC_DEFS_SVH
`define MIPS_EXEC_DEFS_SVH

`define EXEC_XLEN  32
`define DIV_CYCLES 32

// Major opcodes
`define OP_RTYPE  6'h00
`define OP_REGIMM 6'h01
`define OP_BEQ    6'h04
`define OP_BNE    6'h05
`define OP_BLEZ   6'h06
`define OP_BGTZ   6'h07
`define OP_ADDIU  6'h09
`define OP_SLTI   6'h0a
`define OP_SLTIU  6'h0b
`define OP_ANDI   6'h0c
`define OP_ORI    6'h0d
`define OP_XORI   6'h0e
`define OP_LUI    6'h0f
`define OP_LB     6'h20
`define OP_LH     6'h21
`define OP_LW     6'h23
`define OP_LBU    6'h24
`define OP_LHU    6'h25
`define OP_SB     6'h28
`define OP_SH     6'h29
`define OP_SW     6'h2b

// R-type funct codes
`define FN_SLL    6'h00
`define FN_SRL    6'h02
`define FN_SRA    6'h03
`define FN_SLLV   6'h04
`define FN_SRLV   6'h06
`define FN_SRAV   6'h07
`define FN_MFHI   6'h10
`define FN_MTHI   6'h11
`define FN_MFLO   6'h12
`define FN_MTLO   6'h13
`define FN_MULT   6'h18
`define FN_MULTU  6'h19
`define FN_DIV    6'h1a
`define FN_DIVU   6'h1b
`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_XOR    6'h26
`define FN_NOR    6'h27
`define FN_SLT    6'h2a
`define FN_SLTU   6'h2b

// REGIMM rt field codes
`define RI_BLTZ   5'h00
`define RI_BGEZ   5'h01
`define RI_BLTZAL 5'h10
`define RI_BGEZAL 5'h11

`endif

//--- src/mips_exec_pkg.sv
package mips_exec_pkg;

  typedef enum logic [4:0] {
    ALU_NONE, // No result written
    ALU_ADDU,
    ALU_SUBU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLLV,
    ALU_SRLV,
    ALU_SRAV,
    ALU_SLT,
    ALU_SLTU,
    ALU_LUI,
    ALU_MFHI,
    ALU_MFLO
  } alu_op_t;

  typedef enum logic [1:0] {
    IMM_NONE, // Second operand is rt
    IMM_SIGN,
    IMM_ZERO
  } imm_kind_t;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LEZ,
    BR_GTZ,
    BR_LTZ,
    BR_GEZ
  } branch_cond_t;

  typedef enum logic [2:0] {
    MD_NONE,
    MD_MULT,
    MD_MULTU,
    MD_DIV,
    MD_DIVU,
    MD_MTHI,
    MD_MTLO
  } md_op_t;

endpackage

//--- src/instr_decode.sv
`timescale 1ns/1ps
`include "mips_exec_defs.svh"

module instr_decode (
  input  logic [5:0]                  opcode,
  input  logic [5:0]                  funct,
  input  logic [4:0]                  rt_field,
  output mips_exec_pkg::alu_op_t      alu_op,
  output mips_exec_pkg::imm_kind_t    imm_kind,
  output mips_exec_pkg::branch_cond_t branch_cond,
  output mips_exec_pkg::md_op_t       md_op,
  output logic                        illegal
);

  always_comb
  begin
    alu_op      = mips_exec_pkg::ALU_NONE;
    branch_cond = mips_exec_pkg::BR_NONE;
    md_op       = mips_exec_pkg::MD_NONE;
    illegal     = 1'b0;
    case (opcode)
      `OP_RTYPE:
        case (funct)
          `FN_SLL:   alu_op = mips_exec_pkg::ALU_SLL;
          `FN_SRL:   alu_op = mips_exec_pkg::ALU_SRL;
          `FN_SRA:   alu_op = mips_exec_pkg::ALU_SRA;
          `FN_SLLV:  alu_op = mips_exec_pkg::ALU_SLLV;
          `FN_SRLV:  alu_op = mips_exec_pkg::ALU_SRLV;
          `FN_SRAV:  alu_op = mips_exec_pkg::ALU_SRAV;
          `FN_MFHI:  alu_op = mips_exec_pkg::ALU_MFHI;
          `FN_MFLO:  alu_op = mips_exec_pkg::ALU_MFLO;
          `FN_MTHI:  md_op  = mips_exec_pkg::MD_MTHI;
          `FN_MTLO:  md_op  = mips_exec_pkg::MD_MTLO;
          `FN_MULT:  md_op  = mips_exec_pkg::MD_MULT;
          `FN_MULTU: md_op  = mips_exec_pkg::MD_MULTU;
          `FN_DIV:   md_op  = mips_exec_pkg::MD_DIV;
          `FN_DIVU:  md_op  = mips_exec_pkg::MD_DIVU;
          `FN_ADDU:  alu_op = mips_exec_pkg::ALU_ADDU;
          `FN_SUBU:  alu_op = mips_exec_pkg::ALU_SUBU;
          `FN_AND:   alu_op = mips_exec_pkg::ALU_AND;
          `FN_OR:    alu_op = mips_exec_pkg::ALU_OR;
          `FN_XOR:   alu_op = mips_exec_pkg::ALU_XOR;
          `FN_NOR:   alu_op = mips_exec_pkg::ALU_NOR;
          `FN_SLT:   alu_op = mips_exec_pkg::ALU_SLT;
          `FN_SLTU:  alu_op = mips_exec_pkg::ALU_SLTU;
          default:   illegal = 1'b1; // Trapping ADD/SUB and jumps land here
        endcase
      `OP_REGIMM:
        case (rt_field)
          `RI_BLTZ, `RI_BLTZAL: branch_cond = mips_exec_pkg::BR_LTZ; // Link handled upstream
          `RI_BGEZ, `RI_BGEZAL: branch_cond = mips_exec_pkg::BR_GEZ;
          default:              illegal = 1'b1;
        endcase
      `OP_BEQ:   branch_cond = mips_exec_pkg::BR_EQ;
      `OP_BNE:   branch_cond = mips_exec_pkg::BR_NE;
      `OP_BLEZ:  branch_cond = mips_exec_pkg::BR_LEZ;
      `OP_BGTZ:  branch_cond = mips_exec_pkg::BR_GTZ;
      `OP_ADDIU, `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW:
        alu_op = mips_exec_pkg::ALU_ADDU; // Address is rs plus offset
      `OP_SLTI:  alu_op = mips_exec_pkg::ALU_SLT;
      `OP_SLTIU: alu_op = mips_exec_pkg::ALU_SLTU;
      `OP_ANDI:  alu_op = mips_exec_pkg::ALU_AND;
      `OP_ORI:   alu_op = mips_exec_pkg::ALU_OR;
      `OP_XORI:  alu_op = mips_exec_pkg::ALU_XOR;
      `OP_LUI:   alu_op = mips_exec_pkg::ALU_LUI;
      default:   illegal = 1'b1; // LWL, LWR, ADDI and unknown opcodes
    endcase
  end

  // SLTIU also sign-extends, then compares unsigned
  always_comb
  begin
    case (opcode)
      `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
      `OP_SB, `OP_SH, `OP_SW:
        imm_kind = mips_exec_pkg::IMM_SIGN;
      `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI:
        imm_kind = mips_exec_pkg::IMM_ZERO;
      default:
        imm_kind = mips_exec_pkg::IMM_NONE;
    endcase
  end

endmodule

//--- src/alu_core.sv
`timescale 1ns/1ps
`include "mips_exec_defs.svh"

module alu_core (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     issue_valid,
  input  mips_exec_pkg::alu_op_t   alu_op,
  input  mips_exec_pkg::imm_kind_t imm_kind,
  input  logic                     illegal,
  input  logic [4:0]               shamt,
  input  logic [15:0]              immediate,
  input  logic [`EXEC_XLEN-1:0]    rs_value,
  input  logic [`EXEC_XLEN-1:0]    rt_value,
  input  logic [`EXEC_XLEN-1:0]    hi,
  input  logic [`EXEC_XLEN-1:0]    lo,
  output logic                     result_valid,
  output logic [`EXEC_XLEN-1:0]    result,
  output logic                     illegal_instr
);

  logic [`EXEC_XLEN-1:0] op_b;
  logic [`EXEC_XLEN-1:0] alu_out;
  logic [4:0]            sh_amt;

  always_comb
  begin
    case (imm_kind)
      mips_exec_pkg::IMM_SIGN: op_b = {{(`EXEC_XLEN-16){immediate[15]}}, immediate};
      mips_exec_pkg::IMM_ZERO: op_b = {{(`EXEC_XLEN-16){1'b0}}, immediate};
      default:                 op_b = rt_value;
    endcase
  end

  // Variable shifts take the low five bits of rs
  always_comb
  begin
    case (alu_op)
      mips_exec_pkg::ALU_SLLV,
      mips_exec_pkg::ALU_SRLV,
      mips_exec_pkg::ALU_SRAV: sh_amt = rs_value[4:0];
      default:                 sh_amt = shamt;
    endcase
  end

  always_comb
  begin
    case (alu_op)
      mips_exec_pkg::ALU_ADDU: alu_out = rs_value + op_b;
      mips_exec_pkg::ALU_SUBU: alu_out = rs_value - op_b;
      mips_exec_pkg::ALU_AND:  alu_out = rs_value & op_b;
      mips_exec_pkg::ALU_OR:   alu_out = rs_value | op_b;
      mips_exec_pkg::ALU_XOR:  alu_out = rs_value ^ op_b;
      mips_exec_pkg::ALU_NOR:  alu_out = ~(rs_value | op_b);
      mips_exec_pkg::ALU_SLL,
      mips_exec_pkg::ALU_SLLV: alu_out = rt_value << sh_amt;
      mips_exec_pkg::ALU_SRL,
      mips_exec_pkg::ALU_SRLV: alu_out = rt_value >> sh_amt;
      mips_exec_pkg::ALU_SRA,
      mips_exec_pkg::ALU_SRAV: alu_out = $signed(rt_value) >>> sh_amt; // Sign bit fills
      mips_exec_pkg::ALU_SLT:
        alu_out = {{(`EXEC_XLEN-1){1'b0}}, ($signed(rs_value) < $signed(op_b))};
      mips_exec_pkg::ALU_SLTU:
        alu_out = {{(`EXEC_XLEN-1){1'b0}}, (rs_value < op_b)};
      mips_exec_pkg::ALU_LUI:  alu_out = {immediate, {(`EXEC_XLEN-16){1'b0}}};
      mips_exec_pkg::ALU_MFHI: alu_out = hi;
      mips_exec_pkg::ALU_MFLO: alu_out = lo;
      default:                 alu_out = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      result_valid  <= 1'b0;
      illegal_instr <= 1'b0;
    end
    else
    begin
      result_valid  <= issue_valid && (alu_op != mips_exec_pkg::ALU_NONE);
      illegal_instr <= issue_valid && illegal;
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue_valid)
      result <= alu_out;
  end

  // An illegal encoding must never also produce a write
  assert property (@(posedge clk) disable iff (reset) !(result_valid && illegal_instr))
    else $error("result_valid and illegal_instr asserted together");

endmodule

//--- src/branch_unit.sv
`timescale 1ns/1ps
`include "mips_exec_defs.svh"

module branch_unit (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        issue_valid,
  input  mips_exec_pkg::branch_cond_t branch_cond,
  input  logic [`EXEC_XLEN-1:0]       rs_value,
  input  logic [`EXEC_XLEN-1:0]       rt_value,
  output logic                        branch_valid,
  output logic                        branch_taken
);

  logic rs_neg;
  logic rs_zero;
  logic taken;

  assign rs_neg  = rs_value[`EXEC_XLEN-1];
  assign rs_zero = (rs_value == '0);

  always_comb
  begin
    case (branch_cond)
      mips_exec_pkg::BR_EQ:  taken = (rs_value == rt_value);
      mips_exec_pkg::BR_NE:  taken = (rs_value != rt_value);
      mips_exec_pkg::BR_LEZ: taken = rs_neg || rs_zero;
      mips_exec_pkg::BR_GTZ: taken = !rs_neg && !rs_zero;
      mips_exec_pkg::BR_LTZ: taken = rs_neg;
      mips_exec_pkg::BR_GEZ: taken = !rs_neg;
      default:               taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      branch_valid <= 1'b0;
      branch_taken <= 1'b0;
    end
    else
    begin
      branch_valid <= issue_valid && (branch_cond != mips_exec_pkg::BR_NONE);
      branch_taken <= issue_valid && taken; // Low whenever no branch issued
    end
  end

endmodule

//--- src/mult_div_unit.sv
`timescale 1ns/1ps
`include "mips_exec_defs.svh"

module mult_div_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  issue_valid,
  input  mips_exec_pkg::md_op_t md_op,
  input  logic [`EXEC_XLEN-1:0] rs_value,
  input  logic [`EXEC_XLEN-1:0] rt_value,
  output logic                  md_busy,
  output logic                  hilo_we,
  output logic                  write_hi_only,
  output logic                  write_lo_only,
  output logic [`EXEC_XLEN-1:0] hi_next,
  output logic [`EXEC_XLEN-1:0] lo_next
);

  localparam int XLEN  = `EXEC_XLEN;
  localparam int CNT_W = $clog2(`DIV_CYCLES);

  logic                     mul_issue;
  logic                     div_issue;
  logic                     mt_issue;
  logic                     div_signed;
  logic [XLEN-1:0]          mag_a;
  logic [XLEN-1:0]          mag_b;
  logic signed [2*XLEN-1:0] prod_s;
  logic [2*XLEN-1:0]        prod_u;
  logic [2*XLEN-1:0]        prod_q;
  logic                     mul_q;
  logic                     div_q;
  logic                     div_last;
  logic [CNT_W-1:0]         count_q;
  logic [XLEN-1:0]          rem_q;
  logic [XLEN-1:0]          quo_q;
  logic [XLEN-1:0]          dvsr_q;
  logic                     neg_quo_q;
  logic                     neg_rem_q;
  logic [XLEN:0]            shifted;
  logic [XLEN:0]            trial;
  logic [XLEN-1:0]          next_rem;
  logic [XLEN-1:0]          next_quo;

  assign mul_issue = issue_valid &&
                     (md_op == mips_exec_pkg::MD_MULT || md_op == mips_exec_pkg::MD_MULTU);
  assign div_issue = issue_valid &&
                     (md_op == mips_exec_pkg::MD_DIV || md_op == mips_exec_pkg::MD_DIVU);
  assign write_hi_only = issue_valid && (md_op == mips_exec_pkg::MD_MTHI);
  assign write_lo_only = issue_valid && (md_op == mips_exec_pkg::MD_MTLO);
  assign mt_issue      = write_hi_only || write_lo_only; // Bypasses the registers
  assign div_signed    = (md_op == mips_exec_pkg::MD_DIV);

  // Divider works on magnitudes
  assign mag_a = (div_signed && rs_value[XLEN-1]) ? -rs_value : rs_value;
  assign mag_b = (div_signed && rt_value[XLEN-1]) ? -rt_value : rt_value;

  assign prod_s = $signed(rs_value) * $signed(rt_value);
  assign prod_u = rs_value * rt_value;

  // One restoring step per cycle
  assign shifted  = {rem_q, quo_q[XLEN-1]};
  assign trial    = shifted - {1'b0, dvsr_q};
  assign next_rem = trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
  assign next_quo = {quo_q[XLEN-2:0], !trial[XLEN]};
  assign div_last = div_q && (count_q == CNT_W'(`DIV_CYCLES - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mul_q   <= 1'b0;
      div_q   <= 1'b0;
      count_q <= '0;
    end
    else
    begin
      mul_q <= mul_issue; // Product lands one cycle after issue
      if (div_issue)
      begin
        div_q   <= 1'b1;
        count_q <= '0;
      end
      else if (div_last)
        div_q <= 1'b0;
      else if (div_q)
        count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (mul_issue)
      prod_q <= (md_op == mips_exec_pkg::MD_MULT) ? prod_s : prod_u;
    if (div_issue)
    begin
      rem_q     <= '0;
      quo_q     <= mag_a;
      dvsr_q    <= mag_b;
      neg_quo_q <= div_signed && (rs_value[XLEN-1] ^ rt_value[XLEN-1]);
      neg_rem_q <= div_signed && rs_value[XLEN-1]; // Remainder follows dividend
    end
    else if (div_q)
    begin
      rem_q <= next_rem;
      quo_q <= next_quo;
    end
  end

  assign md_busy = mul_q || div_q;
  assign hilo_we = mul_q || div_last || mt_issue;

  // Divide by zero falls out as all-ones quotient and dividend remainder
  always_comb
  begin
    if (mt_issue)
    begin
      hi_next = rs_value;
      lo_next = rs_value;
    end
    else if (div_q)
    begin
      hi_next = neg_rem_q ? -next_rem : next_rem;
      lo_next = neg_quo_q ? -next_quo : next_quo;
    end
    else
    begin
      hi_next = prod_q[2*XLEN-1:XLEN];
      lo_next = prod_q[XLEN-1:0];
    end
  end

  // Issuer must hold HI/LO work until the unit is idle
  assert property (@(posedge clk) disable iff (reset)
    issue_valid && (md_op != mips_exec_pkg::MD_NONE) |-> !md_busy)
    else $error("multiply/divide operation issued while md_busy is high");

  assert property (@(posedge clk) disable iff (reset)
    $rose(md_busy) |-> ##[1:`DIV_CYCLES] !md_busy)
    else $error("md_busy held longer than the divide step count");

endmodule

//--- src/hilo_regs.sv
`timescale 1ns/1ps
`include "mips_exec_defs.svh"

module hilo_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  hilo_we,
  input  logic                  write_hi_only,
  input  logic                  write_lo_only,
  input  logic [`EXEC_XLEN-1:0] hi_next,
  input  logic [`EXEC_XLEN-1:0] lo_next,
  output logic [`EXEC_XLEN-1:0] hi,
  output logic [`EXEC_XLEN-1:0] lo
);

  // Architectural HI and LO
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi <= '0;
      lo <= '0;
    end
    else if (hilo_we)
    begin
      if (!write_lo_only)
        hi <= hi_next; // MTLO leaves HI alone
      if (!write_hi_only)
        lo <= lo_next;
    end
  end

endmodule

//--- src/mips_exec.sv
`timescale 1ns/1ps
`include "mips_exec_defs.svh"

module mips_exec (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  issue_valid,
  input  logic [5:0]            opcode,
  input  logic [5:0]            funct,
  input  logic [4:0]            rt_field,
  input  logic [4:0]            shamt,
  input  logic [15:0]           immediate,
  input  logic [`EXEC_XLEN-1:0] rs_value,
  input  logic [`EXEC_XLEN-1:0] rt_value,
  output logic                  result_valid,
  output logic [`EXEC_XLEN-1:0] result,
  output logic                  branch_valid,
  output logic                  branch_taken,
  output logic                  illegal_instr,
  output logic                  md_busy
);

  mips_exec_pkg::alu_op_t      alu_op;
  mips_exec_pkg::imm_kind_t    imm_kind;
  mips_exec_pkg::branch_cond_t branch_cond;
  mips_exec_pkg::md_op_t       md_op;
  logic                        illegal;
  logic [`EXEC_XLEN-1:0]       hi;
  logic [`EXEC_XLEN-1:0]       lo;
  logic                        hilo_we;
  logic                        write_hi_only;
  logic                        write_lo_only;
  logic [`EXEC_XLEN-1:0]       hi_next;
  logic [`EXEC_XLEN-1:0]       lo_next;

  instr_decode u_decode (
    .opcode      (opcode),
    .funct       (funct),
    .rt_field    (rt_field),
    .alu_op      (alu_op),
    .imm_kind    (imm_kind),
    .branch_cond (branch_cond),
    .md_op       (md_op),
    .illegal     (illegal)
  );

  alu_core u_alu (
    .clk           (clk),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .alu_op        (alu_op),
    .imm_kind      (imm_kind),
    .illegal       (illegal),
    .shamt         (shamt),
    .immediate     (immediate),
    .rs_value      (rs_value),
    .rt_value      (rt_value),
    .hi            (hi),
    .lo            (lo),
    .result_valid  (result_valid),
    .result        (result),
    .illegal_instr (illegal_instr)
  );

  branch_unit u_branch (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .branch_cond  (branch_cond),
    .rs_value     (rs_value),
    .rt_value     (rt_value),
    .branch_valid (branch_valid),
    .branch_taken (branch_taken)
  );

  mult_div_unit u_md (
    .clk           (clk),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .md_op         (md_op),
    .rs_value      (rs_value),
    .rt_value      (rt_value),
    .md_busy       (md_busy),
    .hilo_we       (hilo_we),
    .write_hi_only (write_hi_only),
    .write_lo_only (write_lo_only),
    .hi_next       (hi_next),
    .lo_next       (lo_next)
  );

  hilo_regs u_hilo (
    .clk           (clk),
    .reset         (reset),
    .hilo_we       (hilo_we),
    .write_hi_only (write_hi_only),
    .write_lo_only (write_lo_only),
    .hi_next       (hi_next),
    .lo_next       (lo_next),
    .hi            (hi),
    .lo            (lo)
  );

endmodule

//--- test/tb_mips_exec.sv
`timescale 1ns/1ps
`include "mips_exec_defs.svh"

module tb_mips_exec;

  localparam int TEST_SLOTS = 50;
  localparam int MAX_CYCLES = TEST_SLOTS * (`DIV_CYCLES + 4) + 200;

  logic                  clk;
  logic                  reset;
  logic                  issue_valid;
  logic [5:0]            opcode;
  logic [5:0]            funct;
  logic [4:0]            rt_field;
  logic [4:0]            shamt;
  logic [15:0]           immediate;
  logic [`EXEC_XLEN-1:0] rs_value;
  logic [`EXEC_XLEN-1:0] rt_value;
  logic                  result_valid;
  logic [`EXEC_XLEN-1:0] result;
  logic                  branch_valid;
  logic                  branch_taken;
  logic                  illegal_instr;
  logic                  md_busy;

  int          errors;
  int          cycle_count;
  logic [31:0] rng_state;

  mips_exec u_dut (
    .clk           (clk),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .opcode        (opcode),
    .funct         (funct),
    .rt_field      (rt_field),
    .shamt         (shamt),
    .immediate     (immediate),
    .rs_value      (rs_value),
    .rt_value      (rt_value),
    .result_valid  (result_valid),
    .result        (result),
    .branch_valid  (branch_valid),
    .branch_taken  (branch_taken),
    .illegal_instr (illegal_instr),
    .md_busy       (md_busy)
  );

  always #2 clk = ~clk; // 4 ns period

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Expected ALU result straight from the MIPS instruction definitions
  function automatic logic [31:0] ref_result(input logic [5:0] op, input logic [5:0] fn,
                                             input logic [4:0] sa, input logic [15:0] imm,
                                             input logic [31:0] rs, input logic [31:0] rt);
    logic [31:0] sext;
    logic [31:0] zext;
    logic [63:0] rt_wide;
    sext    = {{16{imm[15]}}, imm};
    zext    = {16'h0000, imm};
    rt_wide = {{32{rt[31]}}, rt}; // Sign-filled copy for arithmetic shifts
    if (op == `OP_RTYPE)
    begin
      case (fn)
        `FN_ADDU: return rs + rt;
        `FN_SUBU: return rs - rt;
        `FN_AND:  return rs & rt;
        `FN_OR:   return rs | rt;
        `FN_XOR:  return rs ^ rt;
        `FN_NOR:  return ~(rs | rt);
        `FN_SLL:  return rt << sa;
        `FN_SRL:  return rt >> sa;
        `FN_SRA:  return 32'(rt_wide >> sa);
        `FN_SLLV: return rt << rs[4:0];
        `FN_SRLV: return rt >> rs[4:0];
        `FN_SRAV: return 32'(rt_wide >> rs[4:0]);
        `FN_SLT:  return ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
        `FN_SLTU: return (rs < rt) ? 32'd1 : 32'd0;
        default:  return 32'd0;
      endcase
    end
    case (op)
      `OP_SLTI:  return ($signed(rs) < $signed(sext)) ? 32'd1 : 32'd0;
      `OP_SLTIU: return (rs < sext) ? 32'd1 : 32'd0;
      `OP_ANDI:  return rs & zext;
      `OP_ORI:   return rs | zext;
      `OP_XORI:  return rs ^ zext;
      `OP_LUI:   return {imm, 16'h0000};
      default:   return rs + sext; // ADDIU and every load/store address
    endcase
  endfunction

  function automatic logic ref_taken(input logic [5:0] op, input logic [4:0] rt_f,
                                     input logic [31:0] rs, input logic [31:0] rt);
    case (op)
      `OP_BEQ:  return rs == rt;
      `OP_BNE:  return rs != rt;
      `OP_BLEZ: return $signed(rs) <= 0;
      `OP_BGTZ: return $signed(rs) > 0;
      default:  return rt_f[0] ? ($signed(rs) >= 0) : ($signed(rs) < 0); // REGIMM
    endcase
  endfunction

  function automatic logic [63:0] ref_product(input logic is_signed,
                                              input logic [31:0] a, input logic [31:0] b);
    longint      sa;
    longint      sb;
    logic [63:0] ua;
    logic [63:0] ub;
    sa = $signed(a);
    sb = $signed(b);
    ua = {32'h0, a};
    ub = {32'h0, b};
    if (is_signed)
      return sa * sb;
    return ua * ub;
  endfunction

  // Returns {remainder, quotient}
  function automatic logic [63:0] ref_divide(input logic is_signed,
                                             input logic [31:0] a, input logic [31:0] b);
    longint sa;
    longint sb;
    sa = $signed(a);
    sb = $signed(b);
    if (b == 32'd0)
      return {a, (is_signed && a[31]) ? 32'h0000_0001 : 32'hffff_ffff}; // Negated all ones
    if (is_signed)
      return {32'(sa % sb), 32'(sa / sb)};
    return {a % b, a / b};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      errors = errors + 1;
      $display("error t=%0t %s expected %h actual %h", $time, name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // Called 1 ns after an edge, returns 1 ns after the capturing edge
  task automatic issue_instr(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] rt_f,
                             input logic [4:0] sa, input logic [15:0] imm,
                             input logic [31:0] rs, input logic [31:0] rt);
    opcode      = op;
    funct       = fn;
    rt_field    = rt_f;
    shamt       = sa;
    immediate   = imm;
    rs_value    = rs;
    rt_value    = rt;
    issue_valid = 1'b1;
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic read_hilo(input logic [31:0] exp_hi, input logic [31:0] exp_lo);
    issue_instr(`OP_RTYPE, `FN_MFHI, 5'd0, 5'd0, 16'd0, 32'd0, 32'd0);
    check_value("result_valid", 1'b1, result_valid);
    check_value("result (MFHI)", exp_hi, result);
    issue_instr(`OP_RTYPE, `FN_MFLO, 5'd0, 5'd0, 16'd0, 32'd0, 32'd0);
    check_value("result_valid", 1'b1, result_valid);
    check_value("result (MFLO)", exp_lo, result);
  endtask

  task automatic test_reset_state();
    check_value("result_valid", 1'b0, result_valid);
    check_value("branch_valid", 1'b0, branch_valid);
    check_value("illegal_instr", 1'b0, illegal_instr);
    check_value("md_busy", 1'b0, md_busy);
    read_hilo(32'd0, 32'd0);
    next_cycle();
  endtask

  task automatic run_alu(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] sa,
                         input logic [15:0] imm, input logic [31:0] rs, input logic [31:0] rt);
    logic [31:0] expected;
    expected = ref_result(op, fn, sa, imm, rs, rt);
    issue_instr(op, fn, 5'd0, sa, imm, rs, rt);
    check_value("result_valid", 1'b1, result_valid);
    check_value("branch_valid", 1'b0, branch_valid);
    check_value("illegal_instr", 1'b0, illegal_instr);
    check_value($sformatf("result op=%h fn=%h", op, fn), expected, result);
    next_cycle();
    check_value("result_valid", 1'b0, result_valid); // Single-cycle strobe
  endtask

  task automatic test_alu_ops();
    logic [5:0] r_functs [14];
    logic [5:0] i_ops [15];
    logic [31:0] rs;
    logic [31:0] rt;
    logic [15:0] imm;
    logic [4:0]  sa;
    r_functs = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLL, `FN_SRL,
                 `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_SLT, `FN_SLTU};
    i_ops    = '{`OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
                 `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW};
    for (int iter = 0; iter < 4; iter++)
    begin
      rs  = next_random();
      rt  = next_random();
      imm = next_random() >> 8;
      sa  = next_random() >> 3;
      foreach (r_functs[i])
        run_alu(`OP_RTYPE, r_functs[i], sa, 16'd0, rs, rt);
      foreach (i_ops[i])
        run_alu(i_ops[i], 6'd0, 5'd0, imm, rs, rt);
    end
    run_alu(`OP_RTYPE, `FN_SRA, 5'd31, 16'd0, 32'd0, 32'h8000_0000);
    run_alu(`OP_RTYPE, `FN_SRAV, 5'd0, 16'd0, 32'hffff_ffe4, 32'h8000_0010);
    run_alu(`OP_SLTIU, 6'd0, 5'd0, 16'hffff, 32'hffff_fffe, 32'd0); // Large unsigned bound
  endtask

  task automatic test_branches();
    logic [5:0]  br_ops [8];
    logic [4:0]  br_rts [8];
    logic [31:0] rs_set [5];
    logic [31:0] rt_set [5];
    logic        expected;
    br_ops = '{`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM, `OP_REGIMM, `OP_REGIMM,
               `OP_REGIMM};
    br_rts = '{5'd0, 5'd0, 5'd0, 5'd0, `RI_BLTZ, `RI_BGEZ, `RI_BLTZAL, `RI_BGEZAL};
    rs_set = '{32'd5, 32'd5, 32'hffff_fff0, 32'd0, 32'h7fff_ffff};
    rt_set = '{32'd5, 32'd9, 32'd3, 32'd0, 32'd1};
    foreach (br_ops[b])
    begin
      foreach (rs_set[k])
      begin
        expected = ref_taken(br_ops[b], br_rts[b], rs_set[k], rt_set[k]);
        issue_instr(br_ops[b], 6'd0, br_rts[b], 5'd0, 16'h0010, rs_set[k], rt_set[k]);
        check_value("branch_valid", 1'b1, branch_valid);
        check_value($sformatf("branch_taken op=%h rt=%h", br_ops[b], br_rts[b]),
                    expected, branch_taken);
        check_value("result_valid", 1'b0, result_valid);
        next_cycle();
        check_value("branch_valid", 1'b0, branch_valid);
      end
    end
  endtask

  task automatic run_mult(input logic is_signed, input logic [31:0] a, input logic [31:0] b);
    logic [63:0] prod;
    prod = ref_product(is_signed, a, b);
    issue_instr(`OP_RTYPE, is_signed ? `FN_MULT : `FN_MULTU, 5'd0, 5'd0, 16'd0, a, b);
    check_value("md_busy", 1'b1, md_busy);
    check_value("result_valid", 1'b0, result_valid);
    next_cycle();
    check_value("md_busy", 1'b0, md_busy); // Product written after one busy cycle
    read_hilo(prod[63:32], prod[31:0]);
  endtask

  task automatic test_mult_moves();
    logic [31:0] a_set [4];
    logic [31:0] b_set [4];
    logic [31:0] hi_val;
    logic [31:0] lo_val;
    a_set = '{32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
    b_set = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'hffff_ffff};
    foreach (a_set[i])
    begin
      run_mult(1'b1, a_set[i], b_set[i]);
      run_mult(1'b0, a_set[i], b_set[i]);
    end
    for (int i = 0; i < 3; i++)
    begin
      run_mult(1'b1, next_random(), next_random());
      run_mult(1'b0, next_random(), next_random());
    end
    hi_val = next_random();
    lo_val = next_random();
    issue_instr(`OP_RTYPE, `FN_MTHI, 5'd0, 5'd0, 16'd0, hi_val, 32'd0);
    check_value("md_busy", 1'b0, md_busy);
    issue_instr(`OP_RTYPE, `FN_MTLO, 5'd0, 5'd0, 16'd0, lo_val, 32'd0);
    check_value("md_busy", 1'b0, md_busy);
    read_hilo(hi_val, lo_val); // MTLO leaves HI alone
    hi_val = next_random();
    issue_instr(`OP_RTYPE, `FN_MTHI, 5'd0, 5'd0, 16'd0, hi_val, 32'd0);
    read_hilo(hi_val, lo_val); // MTHI leaves LO alone
  endtask

  task automatic run_div(input logic is_signed, input logic [31:0] a, input logic [31:0] b,
                         input logic with_addu);
    logic [63:0] expected;
    logic [31:0] x;
    logic [31:0] y;
    int          busy_cycles;
    expected    = ref_divide(is_signed, a, b);
    busy_cycles = 0;
    issue_instr(`OP_RTYPE, is_signed ? `FN_DIV : `FN_DIVU, 5'd0, 5'd0, 16'd0, a, b);
    check_value("md_busy", 1'b1, md_busy);
    if (with_addu)
    begin
      x = next_random();
      y = next_random();
      busy_cycles = busy_cycles + 1;
      issue_instr(`OP_RTYPE, `FN_ADDU, 5'd0, 5'd0, 16'd0, x, y);
      check_value("result_valid", 1'b1, result_valid);
      check_value("result (ADDU during divide)",
                  ref_result(`OP_RTYPE, `FN_ADDU, 5'd0, 16'd0, x, y), result);
    end
    while (md_busy)
    begin
      busy_cycles = busy_cycles + 1;
      next_cycle();
    end
    check_value("md_busy cycle count", `DIV_CYCLES, busy_cycles);
    read_hilo(expected[63:32], expected[31:0]);
  endtask

  task automatic test_divide();
    run_div(1'b0, 32'd100, 32'd7, 1'b0);
    run_div(1'b1, -32'sd100, 32'd7, 1'b0);
    run_div(1'b1, 32'd100, -32'sd7, 1'b0);
    run_div(1'b1, -32'sd100, -32'sd7, 1'b0);
    run_div(1'b1, 32'h8000_0000, 32'hffff_ffff, 1'b0); // Quotient wraps
    run_div(1'b0, 32'd12345, 32'd0, 1'b0);
    run_div(1'b1, 32'd12345, 32'd0, 1'b0);
    run_div(1'b1, -32'sd12345, 32'd0, 1'b0);
    run_div(1'b0, next_random(), next_random() >> 12, 1'b0);
    run_div(1'b1, next_random(), next_random() >> 12, 1'b1);
  endtask

  task automatic run_illegal(input logic [5:0] op, input logic [5:0] fn);
    issue_instr(op, fn, 5'd0, 5'd0, 16'd0, 32'd1, 32'd2);
    check_value($sformatf("illegal_instr op=%h fn=%h", op, fn), 1'b1, illegal_instr);
    check_value("result_valid", 1'b0, result_valid);
    check_value("branch_valid", 1'b0, branch_valid);
    next_cycle();
    check_value("illegal_instr", 1'b0, illegal_instr);
  endtask

  task automatic test_illegal();
    run_illegal(6'h02, 6'd0);      // J is outside this stage
    run_illegal(`OP_RTYPE, 6'h20); // Trapping ADD
  endtask

  initial
  begin
    clk         = 1'b0;
    reset       = 1'b1;
    issue_valid = 1'b0;
    opcode      = 6'd0;
    funct       = 6'd0;
    rt_field    = 5'd0;
    shamt       = 5'd0;
    immediate   = 16'd0;
    rs_value    = '0;
    rt_value    = '0;
    errors      = 0;
    cycle_count = 0;
    rng_state   = 32'd5;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_alu_ops();
    test_branches();
    test_mult_moves();
    test_divide();
    test_illegal();
    if (errors == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- mips_exec.f
+incdir+src
src/mips_exec_pkg.sv
src/instr_decode.sv
src/alu_core.sv
src/branch_unit.sv
src/mult_div_unit.sv
src/hilo_regs.sv
src/mips_exec.sv
test/tb_mips_exec.sv

//--- Bender.yml
package:
  name: mips_exec

sources:
  - include_dirs:
      - src
    files:
      - src/mips_exec_pkg.sv
      - src/instr_decode.sv
      - src/alu_core.sv
      - src/branch_unit.sv
      - src/mult_div_unit.sv
      - src/hilo_regs.sv
      - src/mips_exec.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_mips_exec.sv
